//--- Makefile
SOURCES := $(shell grep -v '^+' verilog.f)

.PHONY: all run clean

all: run

obj_dir/Vcnn_layer_tb: verilog.f $(SOURCES) common/cnn_defs.svh
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module cnn_layer_tb -o Vcnn_layer_tb

run: obj_dir/Vcnn_layer_tb
	./obj_dir/Vcnn_layer_tb | tee sim.log
	@if grep -q "Test failures found" sim.log; then \
		echo "simulation reported errors"; exit 1; fi
	@if ! grep -q "All tests passed!" sim.log; then \
		echo "simulation ended without completing"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- common/cnn_defs.svh
`ifndef CNN_DEFS_SVH
`define CNN_DEFS_SVH

// input image size.
`define CNN_IMG_WIDTH 32
`define CNN_IMG_HEIGHT 32

// data widths.
`define CNN_PIXEL_W 8
`define CNN_WEIGHT_W 8
`define CNN_FEATURE_W 22

// kernel side and number of taps.
`define CNN_KERNEL 3
`define CNN_TAPS 9

// feature map after the valid convolution, then after 2x2 pooling.
`define CNN_FMAP_WIDTH 30
`define CNN_FMAP_HEIGHT 30
`define CNN_POOL_WIDTH 15
`define CNN_POOL_HEIGHT 15

`endif

//--- common/cnn_pkg.sv
`include "cnn_defs.svh"

package cnn_pkg;

	// unsigned image pixel.
	typedef logic [`CNN_PIXEL_W-1:0] pixel_t;

	// signed kernel weight.
	typedef logic signed [`CNN_WEIGHT_W-1:0] weight_t;

	// signed convolution result, wide enough for nine full-scale products.
	typedef logic signed [`CNN_FEATURE_W-1:0] feature_t;

	// 3x3 window, element 0 top left, row-major.
	typedef pixel_t [`CNN_TAPS-1:0] window_t;

	function automatic feature_t feature_max(input feature_t a, input feature_t b);
		feature_t m;
		if (a >= b) begin
			m = a;
		end else begin
			m = b;
		end
		return m;
	endfunction

endpackage

//--- common/cnn_stream_if.sv
// window stream from line buffer to mac array.
interface window_stream_if;
	logic valid;
	logic ready;
	cnn_pkg::window_t window;
	logic last;

	modport source (
		output valid,
		output window,
		output last,
		input ready
	);

	modport sink (
		input valid,
		input window,
		input last,
		output ready
	);
endinterface

// feature stream from mac array to pooling.
interface feature_stream_if;
	logic valid;
	logic ready;
	cnn_pkg::feature_t data;
	logic last;

	modport source (
		output valid,
		output data,
		output last,
		input ready
	);

	modport sink (
		input valid,
		input data,
		input last,
		output ready
	);
endinterface

//--- conv/conv_line_buffer.sv
`include "cnn_defs.svh"

module conv_line_buffer (
	input logic clk,
	input logic rst,
	input logic start,
	input logic pixel_valid,
	output logic pixel_ready,
	input cnn_pkg::pixel_t pixel_data,
	window_stream_if.source win
);
	localparam int COL_W = $clog2(`CNN_IMG_WIDTH);
	localparam int ROW_W = $clog2(`CNN_IMG_HEIGHT);
	localparam int K = `CNN_KERNEL;

	logic [COL_W-1:0] col;
	logic [ROW_W-1:0] row;

	// one row up and two rows up.
	cnn_pkg::pixel_t row_mem1 [`CNN_IMG_WIDTH];
	cnn_pkg::pixel_t row_mem2 [`CNN_IMG_WIDTH];
	cnn_pkg::pixel_t above1;
	cnn_pkg::pixel_t above2;

	cnn_pkg::window_t window_q;
	logic valid_q;
	logic last_q;
	logic accept;

	assign pixel_ready = win.ready || !valid_q;
	assign accept = pixel_valid && pixel_ready;
	assign above1 = row_mem1[col];
	assign above2 = row_mem2[col];

	always_ff @(posedge clk) begin
		if (rst || start) begin
			col <= '0;
			row <= '0;
		end else if (accept) begin
			if (col == COL_W'(`CNN_IMG_WIDTH - 1)) begin
				col <= '0;
				if (row == ROW_W'(`CNN_IMG_HEIGHT - 1)) begin
					row <= '0;
				end else begin
					row <= row + 1'b1;
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// the column moves down one row on each write.
	always_ff @(posedge clk) begin
		if (accept) begin
			row_mem1[col] <= pixel_data;
			row_mem2[col] <= above1;
		end
	end

	// shift left, newest column enters on the right.
	always_ff @(posedge clk) begin
		if (accept) begin
			for (int r = 0; r < K; r++) begin
				for (int c = 0; c < K - 1; c++) begin
					window_q[r*K + c] <= window_q[r*K + c + 1];
				end
			end
			window_q[K-1] <= above2;
			window_q[2*K-1] <= above1;
			window_q[K*K-1] <= pixel_data;
		end
	end

	// window is complete once two columns and two rows precede it.
	always_ff @(posedge clk) begin
		if (rst || start) begin
			valid_q <= 1'b0;
			last_q <= 1'b0;
		end else if (accept) begin
			valid_q <= (col >= COL_W'(K - 1)) && (row >= ROW_W'(K - 1));
			last_q <= (col == COL_W'(`CNN_IMG_WIDTH - 1)) &&
				(row == ROW_W'(`CNN_IMG_HEIGHT - 1));
		end else if (win.ready) begin
			valid_q <= 1'b0;
		end
	end

	assign win.valid = valid_q;
	assign win.window = window_q;
	assign win.last = last_q;

endmodule

//--- conv/conv_mac_array.sv
`include "cnn_defs.svh"

module conv_mac_array (
	input logic clk,
	input logic rst,
	input logic start,
	input logic weight_we,
	input logic [$clog2(`CNN_KERNEL * `CNN_KERNEL)-1:0] weight_addr,
	input cnn_pkg::weight_t weight_data,
	window_stream_if.sink win,
	feature_stream_if.source feat
);
	localparam int TAPS = `CNN_KERNEL * `CNN_KERNEL;
	// unsigned pixel widened by one sign bit, times a signed weight.
	localparam int PROD_W = `CNN_PIXEL_W + 1 + `CNN_WEIGHT_W;

	cnn_pkg::weight_t weights [TAPS];

	logic signed [PROD_W-1:0] products [TAPS];
	logic valid1;
	logic last1;

	cnn_pkg::feature_t sum_next;
	cnn_pkg::feature_t sum_q;
	logic valid2;
	logic last2;

	logic advance;

	// both stages move together when the output slot frees up.
	assign advance = !valid2 || feat.ready;
	assign win.ready = advance;

	always_ff @(posedge clk) begin
		if (weight_we && (weight_addr < TAPS)) begin
			weights[weight_addr] <= weight_data;
		end
	end

	// stage one, products.
	always_ff @(posedge clk) begin
		if (advance && win.valid) begin
			for (int i = 0; i < TAPS; i++) begin
				products[i] <= $signed({1'b0, win.window[i]}) * weights[i];
			end
		end
	end

	always_comb begin
		sum_next = '0;
		for (int i = 0; i < TAPS; i++) begin
			sum_next = sum_next + cnn_pkg::feature_t'(products[i]);
		end
	end

	// stage two, sum.
	always_ff @(posedge clk) begin
		if (advance && valid1) begin
			sum_q <= sum_next;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || start) begin
			valid1 <= 1'b0;
			last1 <= 1'b0;
			valid2 <= 1'b0;
			last2 <= 1'b0;
		end else if (advance) begin
			valid1 <= win.valid;
			last1 <= win.valid && win.last;
			valid2 <= valid1;
			last2 <= last1;
		end
	end

	assign feat.valid = valid2;
	assign feat.data = sum_q;
	assign feat.last = last2;

endmodule

//--- src/cnn_layer_top.sv
`include "cnn_defs.svh"

module cnn_layer_top (
	input logic clk,
	input logic rst,
	input logic start,
	input logic weight_we,
	input logic [$clog2(`CNN_KERNEL * `CNN_KERNEL)-1:0] weight_addr,
	input cnn_pkg::weight_t weight_data,
	input logic pixel_valid,
	output logic pixel_ready,
	input cnn_pkg::pixel_t pixel_data,
	output logic result_valid,
	input logic result_ready,
	output cnn_pkg::feature_t result_data,
	output logic done
);

	window_stream_if win_if ();
	feature_stream_if feat_if ();

	conv_line_buffer line_buffer_inst (
		.clk (clk),
		.rst (rst),
		.start (start),
		.pixel_valid (pixel_valid),
		.pixel_ready (pixel_ready),
		.pixel_data (pixel_data),
		.win (win_if)
	);

	conv_mac_array mac_array_inst (
		.clk (clk),
		.rst (rst),
		.start (start),
		.weight_we (weight_we),
		.weight_addr (weight_addr),
		.weight_data (weight_data),
		.win (win_if),
		.feat (feat_if)
	);

	max_pooling pooling_inst (
		.clk (clk),
		.rst (rst),
		.start (start),
		.feat (feat_if),
		.result_valid (result_valid),
		.result_ready (result_ready),
		.result_data (result_data),
		.done (done)
	);

endmodule

//--- src/max_pooling.sv
`include "cnn_defs.svh"

module max_pooling (
	input logic clk,
	input logic rst,
	input logic start,
	feature_stream_if.sink feat,
	output logic result_valid,
	input logic result_ready,
	output cnn_pkg::feature_t result_data,
	output logic done
);
	localparam int COL_W = $clog2(`CNN_FMAP_WIDTH);
	localparam int ROW_W = $clog2(`CNN_FMAP_HEIGHT);

	logic [COL_W-1:0] col;
	logic [ROW_W-1:0] row;

	// holds the even row while the odd row streams in.
	cnn_pkg::feature_t row_buf [`CNN_FMAP_WIDTH];
	cnn_pkg::feature_t prev;

	cnn_pkg::feature_t top_left;
	cnn_pkg::feature_t top_right;
	cnn_pkg::feature_t pool_max;

	logic accept;
	logic pool_en;
	logic result_last;

	assign feat.ready = result_ready || !result_valid;
	assign accept = feat.valid && feat.ready;
	assign pool_en = accept && col[0] && row[0];

	assign top_left = row_buf[col - 1'b1];
	assign top_right = row_buf[col];
	assign pool_max = cnn_pkg::feature_max(
		cnn_pkg::feature_max(top_left, top_right),
		cnn_pkg::feature_max(prev, feat.data));

	always_ff @(posedge clk) begin
		if (rst || start) begin
			col <= '0;
			row <= '0;
		end else if (accept) begin
			if (col == COL_W'(`CNN_FMAP_WIDTH - 1)) begin
				col <= '0;
				if (row == ROW_W'(`CNN_FMAP_HEIGHT - 1)) begin
					row <= '0;
				end else begin
					row <= row + 1'b1;
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// odd rows must not overwrite the row above.
	always_ff @(posedge clk) begin
		if (accept) begin
			prev <= feat.data;
			if (!row[0]) begin
				row_buf[col] <= feat.data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pool_en) begin
			result_data <= pool_max;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || start) begin
			result_valid <= 1'b0;
			result_last <= 1'b0;
		end else if (pool_en) begin
			result_valid <= 1'b1;
			result_last <= feat.last;
		end else if (result_ready) begin
			result_valid <= 1'b0;
		end
	end

	// pulse once the final pooled result leaves.
	always_ff @(posedge clk) begin
		if (rst || start) begin
			done <= 1'b0;
		end else begin
			done <= result_valid && result_ready && result_last;
		end
	end

endmodule

//--- verification/cnn_layer_props.sv
module cnn_layer_props (
	input logic clk,
	input logic rst,
	input logic result_valid,
	input logic result_ready,
	input cnn_pkg::feature_t result_data,
	input logic done
);

	// a stalled result keeps its value.
	property result_held;
		@(posedge clk) disable iff (rst)
			result_valid && !result_ready |=> $stable(result_data);
	endproperty

	property done_single;
		@(posedge clk) disable iff (rst)
			done |=> !done;
	endproperty

	// outputs idle right after a reset edge.
	property reset_idle;
		@(posedge clk) rst |=> !result_valid && !done;
	endproperty

	assert property (result_held) else $error("result_data changed while stalled");
	assert property (done_single) else $error("done high for two cycles");
	assert property (reset_idle) else $error("result_valid or done high after reset");

endmodule

bind cnn_layer_top cnn_layer_props props_inst (
	.clk (clk),
	.rst (rst),
	.result_valid (result_valid),
	.result_ready (result_ready),
	.result_data (result_data),
	.done (done)
);

//--- verification/cnn_layer_tb.sv
`include "cnn_defs.svh"

module cnn_layer_tb;
	localparam int CLK_PERIOD = 20;
	localparam int FRAME_PIXELS = `CNN_IMG_WIDTH * `CNN_IMG_HEIGHT;
	localparam int POOL_RESULTS = `CNN_POOL_WIDTH * `CNN_POOL_HEIGHT;
	localparam int PARTIAL_PIXELS = 70;
	// six full frames and one partial.
	localparam int TOTAL_PIXELS = 6 * FRAME_PIXELS + PARTIAL_PIXELS;

	logic clk;
	logic rst;
	logic start;
	logic weight_we;
	logic [3:0] weight_addr;
	cnn_pkg::weight_t weight_data;
	logic pixel_valid;
	logic pixel_ready;
	cnn_pkg::pixel_t pixel_data;
	logic result_valid;
	logic result_ready;
	cnn_pkg::feature_t result_data;
	logic done;

	logic [31:0] lfsr_state = 32'hbda2efbe;
	cnn_pkg::pixel_t pix [FRAME_PIXELS];
	cnn_pkg::weight_t w [`CNN_TAPS];
	cnn_pkg::feature_t expected_q [$];
	logic stall_results = 1'b0;
	logic done_due = 1'b0;
	int frame_results = 0;
	int done_count = 0;

	cnn_layer_top cnn_layer_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic lfsr_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b) begin
			lfsr_state = lfsr_state ^ 32'h80200003;
		end
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s expected %h actual %h", name, expected, actual);
			$display("Test failures found");
			$fatal(1, "mismatch");
		end
	endtask

	// valid convolution, then 2x2 max with stride 2, row-major.
	task automatic build_expected();
		cnn_pkg::feature_t fmap [`CNN_FMAP_HEIGHT][`CNN_FMAP_WIDTH];
		cnn_pkg::feature_t top;
		cnn_pkg::feature_t bottom;
		int acc;
		for (int y = 0; y < `CNN_FMAP_HEIGHT; y++) begin
			for (int x = 0; x < `CNN_FMAP_WIDTH; x++) begin
				acc = 0;
				for (int r = 0; r < `CNN_KERNEL; r++) begin
					for (int c = 0; c < `CNN_KERNEL; c++) begin
						acc += int'(pix[(y + r) * `CNN_IMG_WIDTH + x + c]) *
							int'(w[r * `CNN_KERNEL + c]);
					end
				end
				fmap[y][x] = cnn_pkg::feature_t'(acc);
			end
		end
		for (int i = 0; i < `CNN_POOL_HEIGHT; i++) begin
			for (int j = 0; j < `CNN_POOL_WIDTH; j++) begin
				top = cnn_pkg::feature_max(fmap[2*i][2*j], fmap[2*i][2*j+1]);
				bottom = cnn_pkg::feature_max(fmap[2*i+1][2*j], fmap[2*i+1][2*j+1]);
				expected_q.push_back(cnn_pkg::feature_max(top, bottom));
			end
		end
	endtask

	task automatic random_pixels();
		for (int i = 0; i < FRAME_PIXELS; i++) begin
			pix[i] = cnn_pkg::pixel_t'(rand_bits(8));
		end
	endtask

	task automatic load_weights();
		for (int i = 0; i < `CNN_TAPS; i++) begin
			@(posedge clk);
			#1;
			weight_we = 1'b1;
			weight_addr = 4'(i);
			weight_data = w[i];
		end
		@(posedge clk);
		#1;
		weight_we = 1'b0;
	endtask

	// a pixel not yet taken keeps valid high.
	task automatic send_pixels(input int n, input logic gaps);
		int i;
		logic next_valid;
		i = 0;
		next_valid = gaps ? lfsr_bit() : 1'b1;
		while (i < n) begin
			@(posedge clk);
			#1;
			pixel_valid = next_valid;
			pixel_data = pix[i];
			@(negedge clk);
			if (pixel_valid && pixel_ready) begin
				i++;
			end
			if (!pixel_valid || pixel_ready) begin
				next_valid = gaps ? lfsr_bit() : 1'b1;
			end
		end
		@(posedge clk);
		#1;
		pixel_valid = 1'b0;
	endtask

	task automatic run_frame(input logic gaps);
		int seen;
		seen = done_count;
		build_expected();
		send_pixels(FRAME_PIXELS, gaps);
		wait (done_count == seen + 1);
		check_value("results left", 0, expected_q.size());
	endtask

	// result_ready, result compare and done check.
	initial begin
		@(negedge rst);
		forever begin
			@(posedge clk);
			#1;
			result_ready = stall_results ? lfsr_bit() : 1'b1;
			@(negedge clk);
			check_value("done", done_due, done);
			if (done) begin
				done_count++;
			end
			done_due = 1'b0;
			if (result_valid && result_ready) begin
				if (expected_q.size() == 0) begin
					fail_run("a result arrived while none was expected");
				end else begin
					check_value("result_data", expected_q.pop_front(), result_data);
					frame_results++;
					if (frame_results == POOL_RESULTS) begin
						frame_results = 0;
						done_due = 1'b1;
					end
				end
			end
		end
	end

	task automatic test_identity();
		for (int i = 0; i < `CNN_TAPS; i++) begin
			w[i] = '0;
		end
		w[4] = 8'sd1;
		random_pixels();
		load_weights();
		run_frame(1'b0);
	endtask

	task automatic test_random_weights();
		for (int i = 0; i < `CNN_TAPS; i++) begin
			w[i] = cnn_pkg::weight_t'(rand_bits(8));
		end
		random_pixels();
		load_weights();
		run_frame(1'b0);
	endtask

	// same weights and pixels as before, now with back-pressure.
	task automatic test_stalls();
		stall_results = 1'b1;
		run_frame(1'b1);
		stall_results = 1'b0;
	endtask

	// nonzero pixels make every feature strictly negative.
	task automatic test_negative();
		logic [6:0] mag;
		for (int i = 0; i < `CNN_TAPS; i++) begin
			mag = 7'(rand_bits(7));
			w[i] = {1'b1, mag};
		end
		for (int i = 0; i < FRAME_PIXELS; i++) begin
			pix[i] = cnn_pkg::pixel_t'(rand_bits(8)) | 8'h01;
		end
		load_weights();
		run_frame(1'b0);
	endtask

	task automatic test_restart();
		random_pixels();
		send_pixels(PARTIAL_PIXELS, 1'b0);
		@(posedge clk);
		#1;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		random_pixels();
		run_frame(1'b0);
	endtask

	task automatic test_done();
		stall_results = 1'b1;
		random_pixels();
		run_frame(1'b1);
		stall_results = 1'b0;
		// a stray second done would still be seen here.
		repeat (8) @(posedge clk);
	endtask

	initial begin
		#(4 * TOTAL_PIXELS * CLK_PERIOD);
		fail_run("timeout: the tests did not finish in the allowed time");
	end

	initial begin
		rst = 1'b1;
		start = 1'b0;
		weight_we = 1'b0;
		weight_addr = '0;
		weight_data = '0;
		pixel_valid = 1'b0;
		pixel_data = '0;
		result_ready = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		test_identity();
		test_random_weights();
		test_stalls();
		test_negative();
		test_restart();
		test_done();
		$display("All tests passed!");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+common
common/cnn_pkg.sv
common/cnn_stream_if.sv
conv/conv_line_buffer.sv
conv/conv_mac_array.sv
src/max_pooling.sv
src/cnn_layer_top.sv
verification/cnn_layer_props.sv
verification/cnn_layer_tb.sv
